// File: rtl/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 64;                  // Data and address width of RV64

  typedef logic [xlen-1:0] xlen_t;           // Register value, PC or immediate
  typedef logic [31:0]     inst_t;           // One instruction word
  typedef logic [4:0]      reg_idx_t;        // Architectural register number
  typedef logic [6:0]      opcode_t;         // Major opcode, inst[6:0]

  // Major opcodes of the supported subset
  localparam opcode_t op_imm    = 7'b0010011;
  localparam opcode_t op_reg    = 7'b0110011;
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_jal    = 7'b1101111;
  localparam opcode_t op_branch = 7'b1100011;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_pass                                 // Second operand straight through, LUI
  } alu_op_e;

  typedef enum logic [2:0] {
    kind_alu,                                // Register or immediate ALU op, LUI
    kind_beq,
    kind_bne,
    kind_jal,
    kind_nop                                 // Anything outside the subset
  } instr_kind_e;

  // Fetch request sequencing, one request in flight at most
  typedef enum logic [1:0] {
    fetch_idle,
    fetch_request,
    fetch_wait
  } fetch_state_e;

endpackage

// File: rtl/pipe_control.sv
`timescale 1ns/10ps

module pipe_control (
  input  logic             clk,
  input  logic             reset,
  input  logic             id_valid,
  input  rv_pkg::reg_idx_t id_rs1,
  input  rv_pkg::reg_idx_t id_rs2,
  input  logic             ex_valid,
  input  logic             ex_writes,
  input  rv_pkg::reg_idx_t ex_rd,
  input  logic             redirect_valid,
  input  logic             fetch_outstanding,
  input  logic             imem_rsp_valid,
  output logic             stall_decode,
  output logic             flush_front,
  output logic             discard_rsp
);

  logic ex_producer;                         // Execute holds a result not yet written
  logic rs1_hit;
  logic rs2_hit;
  logic discard_q;                           // Response in flight belongs to the old path

  assign ex_producer = ex_valid && ex_writes && (ex_rd != '0);
  assign rs1_hit     = (id_rs1 != '0) && (id_rs1 == ex_rd);  // x0 never hazards
  assign rs2_hit     = (id_rs2 != '0) && (id_rs2 == ex_rd);

  // Decode waits one cycle until the producer reaches write-back,
  // where the register file bypass hands the value over.
  // A redirect kills the decode instruction, so no stall then
  assign stall_decode = id_valid && ex_producer && (rs1_hit || rs2_hit) && !redirect_valid;

  assign flush_front = redirect_valid;       // Clears IF/ID and ID/EX
  assign discard_rsp = discard_q;

  // A response on the redirect edge itself is already dropped by the flush,
  // so the flag is only armed when the response is still to come
  always_ff @(posedge clk) begin
    if (reset) begin
      discard_q <= 1'b0;
    end else if (imem_rsp_valid) begin
      discard_q <= 1'b0;                     // Stale response has drained
    end else if (redirect_valid && fetch_outstanding) begin
      discard_q <= 1'b1;
    end
  end

endmodule

// File: rtl/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit #(
  parameter rv_pkg::xlen_t boot_addr = '0
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          stall_decode,
  input  logic          flush_front,
  input  logic          discard_rsp,
  input  logic          redirect_valid,
  input  rv_pkg::xlen_t redirect_pc,
  input  logic          imem_req_ready,
  input  logic          imem_rsp_valid,
  input  rv_pkg::inst_t imem_rsp_data,
  output logic          imem_req_valid,
  output rv_pkg::xlen_t imem_req_addr,
  output logic          fetch_outstanding,
  output logic          if_valid,
  output rv_pkg::inst_t if_inst,
  output rv_pkg::xlen_t if_pc
);
  import rv_pkg::*;

  fetch_state_e state;
  xlen_t        pc;                          // Next address to fetch
  xlen_t        req_addr;                    // Held stable until the memory takes it
  logic         issue;
  logic         rsp_load;

  // IF/ID empty or moving into decode this cycle, and no redirect pending
  assign issue    = (state == fetch_idle) && (!if_valid || !stall_decode) && !flush_front;
  assign rsp_load = (state == fetch_wait) && imem_rsp_valid && !discard_rsp && !flush_front;

  assign imem_req_valid    = (state == fetch_request);
  assign imem_req_addr     = req_addr;
  assign fetch_outstanding = (state != fetch_idle);  // Includes a request not yet taken

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= fetch_idle;
      pc       <= boot_addr;
      if_valid <= 1'b0;
    end else begin
      case (state)
        fetch_idle:    if (issue) state <= fetch_request;
        fetch_request: if (imem_req_ready) state <= fetch_wait;
        fetch_wait:    if (imem_rsp_valid) state <= fetch_idle;  // Stale ones too
        default:       state <= fetch_idle;
      endcase
      if (redirect_valid) begin
        pc <= redirect_pc;                   // A request in flight keeps its address
      end else if (issue) begin
        pc <= pc + 'd4;
      end
      if (flush_front) if_valid <= 1'b0;
      else if (rsp_load) if_valid <= 1'b1;
      else if (!stall_decode) if_valid <= 1'b0;  // Taken by decode
    end
  end

  always_ff @(posedge clk) begin
    if (issue) req_addr <= pc;
    if (rsp_load) begin
      if_inst <= imem_rsp_data;
      if_pc   <= req_addr;
    end
  end

endmodule

// File: rtl/decode_unit.sv
`timescale 1ns/10ps

module decode_unit (
  input  logic                clk,
  input  logic                reset,
  input  logic                stall_decode,
  input  logic                flush_front,
  input  logic                if_valid,
  input  rv_pkg::inst_t       if_inst,
  input  rv_pkg::xlen_t       if_pc,
  input  rv_pkg::xlen_t       rs1_data,
  input  rv_pkg::xlen_t       rs2_data,
  output logic                id_valid,
  output rv_pkg::reg_idx_t    id_rs1,
  output rv_pkg::reg_idx_t    id_rs2,
  output logic                ex_valid,
  output rv_pkg::instr_kind_e ex_kind,
  output rv_pkg::alu_op_e     ex_alu_op,
  output logic                ex_use_imm,
  output rv_pkg::reg_idx_t    ex_rd,
  output logic                ex_writes,
  output rv_pkg::xlen_t       ex_pc,
  output rv_pkg::xlen_t       ex_imm,
  output rv_pkg::xlen_t       ex_a,
  output rv_pkg::xlen_t       ex_b
);
  import rv_pkg::*;

  opcode_t     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  xlen_t       imm_i;
  xlen_t       imm_u;
  xlen_t       imm_b;
  xlen_t       imm_j;
  instr_kind_e kind;
  alu_op_e     alu_op;
  xlen_t       imm;
  logic        use_imm;
  logic        writes;
  logic        use_rs1;
  logic        use_rs2;
  logic        legal;

  assign opcode = if_inst[6:0];
  assign funct3 = if_inst[14:12];
  assign funct7 = if_inst[31:25];

  // Sign-extended immediates, inst[31] is always the sign
  assign imm_i = {{52{if_inst[31]}}, if_inst[31:20]};
  assign imm_u = {{32{if_inst[31]}}, if_inst[31:12], 12'b0};
  assign imm_b = {{51{if_inst[31]}}, if_inst[31], if_inst[7], if_inst[30:25],
                  if_inst[11:8], 1'b0};
  assign imm_j = {{43{if_inst[31]}}, if_inst[31], if_inst[19:12], if_inst[20],
                  if_inst[30:21], 1'b0};

  always_comb begin
    kind    = kind_alu;
    alu_op  = alu_add;
    imm     = imm_i;
    use_imm = 1'b0;
    writes  = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    legal   = 1'b1;
    case (opcode)
      op_imm: begin
        {use_imm, writes, use_rs1} = 3'b111;
        case (funct3)
          3'b000:  alu_op = alu_add;         // ADDI
          3'b100:  alu_op = alu_xor;
          3'b110:  alu_op = alu_or;
          3'b111:  alu_op = alu_and;
          default: legal = 1'b0;             // Shifts and compares
        endcase
      end
      op_reg: begin
        {writes, use_rs1, use_rs2} = 3'b111;
        case ({funct7, funct3})
          10'b0000000_000: alu_op = alu_add;
          10'b0100000_000: alu_op = alu_sub;
          10'b0000000_111: alu_op = alu_and;
          10'b0000000_110: alu_op = alu_or;
          10'b0000000_100: alu_op = alu_xor;
          default:         legal = 1'b0;
        endcase
      end
      op_lui: begin
        {use_imm, writes} = 2'b11;
        alu_op = alu_pass;
        imm    = imm_u;
      end
      op_jal: begin
        kind   = kind_jal;
        writes = 1'b1;                       // Link value pc+4
        imm    = imm_j;
      end
      op_branch: begin
        {use_rs1, use_rs2} = 2'b11;
        imm = imm_b;
        if (funct3 == 3'b000) kind = kind_beq;
        else if (funct3 == 3'b001) kind = kind_bne;
        else legal = 1'b0;
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      kind    = kind_nop;                    // Flows down and retires silently
      writes  = 1'b0;
      use_rs1 = 1'b0;
      use_rs2 = 1'b0;
    end
  end

  // Unused sources read as x0 so they never raise a hazard
  assign id_valid = if_valid;
  assign id_rs1   = use_rs1 ? if_inst[19:15] : '0;
  assign id_rs2   = use_rs2 ? if_inst[24:20] : '0;

  always_ff @(posedge clk) begin
    if (reset) ex_valid <= 1'b0;
    else ex_valid <= if_valid && !stall_decode && !flush_front;  // Bubble otherwise
  end

  always_ff @(posedge clk) begin
    ex_kind    <= kind;
    ex_alu_op  <= alu_op;
    ex_use_imm <= use_imm;
    ex_rd      <= if_inst[11:7];
    ex_writes  <= writes;
    ex_pc      <= if_pc;
    ex_imm     <= imm;
    ex_a       <= rs1_data;
    ex_b       <= rs2_data;
  end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/10ps

module reg_file (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  logic             we,
  input  rv_pkg::reg_idx_t wr_rd,
  input  rv_pkg::xlen_t    wr_data,
  output rv_pkg::xlen_t    rs1_data,
  output rv_pkg::xlen_t    rs2_data
);
  import rv_pkg::*;

  xlen_t regs [32];                          // Entry 0 cleared and never written

  // Same-cycle write is forwarded, x0 reads zero
  assign rs1_data = (rs1 == '0) ? '0 : (we && wr_rd == rs1) ? wr_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : (we && wr_rd == rs2) ? wr_data : regs[rs2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (we && wr_rd != '0) begin
      regs[wr_rd] <= wr_data;
    end
  end

endmodule

// File: rtl/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
  input  logic                clk,
  input  logic                reset,
  input  logic                ex_valid,
  input  rv_pkg::instr_kind_e ex_kind,
  input  rv_pkg::alu_op_e     ex_alu_op,
  input  logic                ex_use_imm,
  input  rv_pkg::reg_idx_t    ex_rd,
  input  logic                ex_writes,
  input  rv_pkg::xlen_t       ex_pc,
  input  rv_pkg::xlen_t       ex_imm,
  input  rv_pkg::xlen_t       ex_a,
  input  rv_pkg::xlen_t       ex_b,
  output logic                redirect_valid,
  output rv_pkg::xlen_t       redirect_pc,
  output logic                commit_valid,
  output rv_pkg::reg_idx_t    commit_rd,
  output rv_pkg::xlen_t       commit_data
);
  import rv_pkg::*;

  xlen_t op_b;
  xlen_t alu_res;
  xlen_t link;                               // Return address for JAL
  logic  taken;

  assign op_b = ex_use_imm ? ex_imm : ex_b;
  assign link = ex_pc + 'd4;

  always_comb begin
    case (ex_alu_op)
      alu_sub:  alu_res = ex_a - op_b;
      alu_and:  alu_res = ex_a & op_b;
      alu_or:   alu_res = ex_a | op_b;
      alu_xor:  alu_res = ex_a ^ op_b;
      alu_pass: alu_res = op_b;              // LUI, immediate already shifted
      default:  alu_res = ex_a + op_b;
    endcase
  end

  // Branches always compare the two register operands
  always_comb begin
    case (ex_kind)
      kind_jal: taken = 1'b1;
      kind_beq: taken = (ex_a == ex_b);
      kind_bne: taken = (ex_a != ex_b);
      default:  taken = 1'b0;
    endcase
  end

  assign redirect_valid = ex_valid && taken;  // Same cycle as the branch sits in ID/EX
  assign redirect_pc    = ex_pc + ex_imm;

  always_ff @(posedge clk) begin
    if (reset) commit_valid <= 1'b0;
    else commit_valid <= ex_valid && ex_writes && (ex_rd != '0);  // x0 writes vanish
  end

  always_ff @(posedge clk) begin
    commit_rd   <= ex_rd;
    commit_data <= (ex_kind == kind_jal) ? link : alu_res;
  end

endmodule

// File: rtl/rv_core.sv
`timescale 1ns/10ps

module rv_core #(
  parameter rv_pkg::xlen_t boot_addr = '0
) (
  input  logic             clk,
  input  logic             reset,
  output logic             imem_req_valid,
  input  logic             imem_req_ready,
  output rv_pkg::xlen_t    imem_req_addr,
  input  logic             imem_rsp_valid,
  input  rv_pkg::inst_t    imem_rsp_data,
  output logic             commit_valid,     // Write-back bus, also the register write port
  output rv_pkg::reg_idx_t commit_rd,
  output rv_pkg::xlen_t    commit_data
);
  import rv_pkg::*;

  // Pipeline control
  logic        stall_decode;
  logic        flush_front;
  logic        discard_rsp;
  logic        fetch_outstanding;
  logic        redirect_valid;
  xlen_t       redirect_pc;

  // IF/ID
  logic        if_valid;
  inst_t       if_inst;
  xlen_t       if_pc;

  // Decode sources
  logic        id_valid;
  reg_idx_t    id_rs1;
  reg_idx_t    id_rs2;
  xlen_t       rs1_data;
  xlen_t       rs2_data;

  // ID/EX
  logic        ex_valid;
  instr_kind_e ex_kind;
  alu_op_e     ex_alu_op;
  logic        ex_use_imm;
  reg_idx_t    ex_rd;
  logic        ex_writes;
  xlen_t       ex_pc;
  xlen_t       ex_imm;
  xlen_t       ex_a;
  xlen_t       ex_b;

  pipe_control u_pipe_control (.*);

  fetch_unit #(
    .boot_addr(boot_addr)
  ) u_fetch_unit (.*);

  decode_unit u_decode_unit (.*);

  // Decode reads, write-back writes
  reg_file u_reg_file (
    .clk     (clk),
    .reset   (reset),
    .rs1     (id_rs1),
    .rs2     (id_rs2),
    .we      (commit_valid),
    .wr_rd   (commit_rd),
    .wr_data (commit_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  execute_unit u_execute_unit (.*);

endmodule

// File: tb/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;

  localparam logic [31:0] nop_word = 32'h0000_0013;  // addi x0, x0, 0

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  logic        imem_req_valid;
  logic        imem_req_ready = 1'b0;
  logic [63:0] imem_req_addr;
  logic        imem_rsp_valid = 1'b0;
  logic [31:0] imem_rsp_data = '0;
  logic        commit_valid;
  logic [4:0]  commit_rd;
  logic [63:0] commit_data;

  logic [31:0] prog [logic [63:0]];          // Program words by byte address
  logic [63:0] exp_rd_q [$];                 // Expected commits in order
  logic [63:0] exp_data_q [$];
  logic [63:0] want_rd;
  logic [63:0] want_data;
  logic [63:0] rsp_addr;                     // Address of the request in flight
  logic        taking = 1'b0;                // Request accepted at the last rising edge
  logic        rsp_pending = 1'b0;
  logic        req_held = 1'b0;              // Request left waiting at the last falling edge
  logic [63:0] held_addr;
  int          rsp_delay;
  int          cycles = 0;
  int          limit;
  int          n_lines = 0;
  int          mismatches = 0;
  int          other_errors = 0;
  int          seed;

  rv_core #(
    .boot_addr(64'h0)
  ) dut (.*);

  always #50 clk = ~clk;                     // 100 ns period

  always @(posedge clk) cycles <= cycles + 1;

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] want);
    if (got !== want) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
      mismatches++;
    end
  endtask

  // Instruction memory answering one request at a time after 1 to 4 cycles
  always @(negedge clk) begin
    imem_rsp_valid = 1'b0;
    if (taking) begin
      rsp_pending = 1'b1;
      rsp_delay   = 1 + int'($urandom % 4);
      taking      = 1'b0;
    end
    if (rsp_pending) begin
      if (rsp_delay == 1) begin
        imem_rsp_valid = 1'b1;
        imem_rsp_data  = prog.exists(rsp_addr) ? prog[rsp_addr] : nop_word;
        rsp_pending    = 1'b0;
      end else begin
        rsp_delay = rsp_delay - 1;
      end
    end
    if (req_held) begin                      // Back-pressure keeps the request in place
      check_value("held request valid", 64'(imem_req_valid), 64'd1);
      check_value("held request address", imem_req_addr, held_addr);
    end
    if (imem_req_valid === 1'b1 && (rsp_pending || imem_rsp_valid)) begin
      $display("Error at %0t: fetch request raised while another is outstanding", $time);
      other_errors++;
    end
    imem_req_ready = ($urandom % 4) != 0;    // Ready three times in four
    req_held       = imem_req_valid && !imem_req_ready;
    held_addr      = imem_req_addr;
    if (imem_req_valid && imem_req_ready) begin
      taking   = 1'b1;                       // Taken at the coming rising edge
      rsp_addr = imem_req_addr;
    end
  end

  // Commit port is registered and steady at the falling edge
  always @(negedge clk) begin
    if (commit_valid === 1'b1) begin
      if (exp_rd_q.size() == 0) begin
        $display("Error at %0t: extra commit to x%0d after the last expected one",
                 $time, commit_rd);
        other_errors++;
      end else begin
        want_rd   = exp_rd_q.pop_front();
        want_data = exp_data_q.pop_front();
        check_value("commit rd", 64'(commit_rd), want_rd);
        check_value("commit data", commit_data, want_data);
      end
    end
  end

  initial begin
    int          fd;
    int          code;
    string       line;
    logic [63:0] a;
    logic [63:0] b;
    seed = $urandom(32'he983_b41f);
    fd = $fopen("tb/rv_trace.txt", "r");
    if (fd == 0) begin
      $display("Error: the trace file tb/rv_trace.txt could not be opened");
      other_errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 2 && line.getc(0) != "#") begin
          code = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, b);  // Trailing notes skipped
          if (code != 2) begin
            $display("Error: trace line not understood: %s", line);
            other_errors++;
          end else if (line.getc(0) == "I") begin
            prog[a] = b[31:0];
            n_lines++;
          end else if (line.getc(0) == "C") begin
            exp_rd_q.push_back(a);
            exp_data_q.push_back(b);
            n_lines++;
          end
        end
      end
      $fclose(fd);
      if (exp_rd_q.size() == 0) begin
        $display("Error: the trace holds no expected commits");
        other_errors++;
      end
    end
    limit = 40 * n_lines + 100;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    while (exp_rd_q.size() != 0 && cycles < limit) @(negedge clk);
    if (exp_rd_q.size() != 0) begin
      $display("Error: timeout after %0d cycles with %0d commits still missing",
               cycles, exp_rd_q.size());
      other_errors++;
    end else begin
      repeat (20) @(negedge clk);            // Idle window for stray commits
    end
    $display("Done: %0d mismatches, %0d other errors", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: tb/rv_trace.txt
# I <byte address> <instruction word>   program memory, hex
# C <rd> <value>                         expected commit in order, hex
I 00 FFB00093 addi x1, x0, -5
I 04 0F00C113 xori x2, x1, 0xf0
I 08 7FF06193 ori x3, x0, 0x7ff
I 0C FF017213 andi x4, x2, -16
I 10 001182B3 add x5, x3, x1
I 14 40328333 sub x6, x5, x3
I 18 004373B3 and x7, x6, x4
I 1C 0033E433 or x8, x7, x3
I 20 001444B3 xor x9, x8, x1
I 24 80000537 lui x10, 0x80000
I 28 00108013 addi x0, x1, 1
I 2C 00003583 ld x11, 0(x0) outside the subset
I 30 00608663 beq x1, x6, +12 taken
I 34 00100593 addi x11, x0, 1 shadow
I 38 00200613 addi x12, x0, 2 shadow
I 3C 00609463 bne x1, x6, +8 not taken
I 40 12300693 addi x13, x0, 0x123
I 44 00349663 bne x9, x3, +12 taken
I 48 00700713 addi x14, x0, 7 shadow
I 4C 00800793 addi x15, x0, 8 shadow
I 50 00348463 beq x9, x3, +8 not taken
I 54 0100086F jal x16, +16
I 58 00900893 addi x17, x0, 9 shadow
I 5C 00A00913 addi x18, x0, 10 shadow
I 60 00B00993 addi x19, x0, 11 shadow
I 64 00980A33 add x20, x16, x9
C 01 FFFFFFFFFFFFFFFB
C 02 FFFFFFFFFFFFFF0B
C 03 00000000000007FF
C 04 FFFFFFFFFFFFFF00
C 05 00000000000007FA
C 06 FFFFFFFFFFFFFFFB
C 07 FFFFFFFFFFFFFF00
C 08 FFFFFFFFFFFFFFFF
C 09 0000000000000004
C 0A FFFFFFFF80000000
C 0D 0000000000000123
C 10 0000000000000058
C 14 000000000000005C

// File: rv_core.f
rtl/rv_pkg.sv
rtl/pipe_control.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/rv_core.sv
tb/tb_rv_core.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_rv_core -f rv_core.f -o sim_rv_core \
  && ./obj_dir/sim_rv_core > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx ">>> PASS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
